//--- build.f
rtl/adc_pkg.sv
rtl/adc_wb_regs.sv
rtl/adc_scan_seq.sv
rtl/adc_result_out.sv
rtl/adc_subsystem.sv
dv/adc_conv_model.sv
dv/adc_tb.sv

//--- dv/adc_conv_model.sv
module adc_conv_model (
  input  logic                          wb_clk_i,
  input  logic                          start_i,
  input  logic [adc_pkg::CHAN_W-1:0]    chnum_i,
  input  logic                          cal_req_i,
  output logic                          calibrate_o,
  output logic                          datavalid_o,
  output logic [adc_pkg::ADC_RES_W-1:0] result_o
);

  logic [31:0]               seed;
  logic [adc_pkg::CHAN_W-1:0] chan;
  int                        delay;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  assign calibrate_o = cal_req_i;  // Calibration is requested by the testbench

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Conversion timing, outputs change on the falling edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    seed        = 32'hba6a_90ca;
    datavalid_o = 1'b0;
    result_o    = '0;
    forever begin
      @(negedge wb_clk_i);
      if (start_i) begin
        chan  = chnum_i;  // Channel is latched with the start pulse
        seed  = lcg_next(seed);
        delay = 3 + int'(seed[27:24]);  // 3 to 18 cycles
        repeat (delay) @(negedge wb_clk_i);
        result_o    = 12'((int'(chan) * 97 + 5) % 4096);
        datavalid_o = 1'b1;
        repeat (2) @(negedge wb_clk_i);
        datavalid_o = 1'b0;
      end
    end
  end

endmodule

//--- dv/adc_tb.sv
module adc_tb;

  localparam logic [31:0] LCG_SEED = 32'hba6a_90ca;
  // About 80 cycles per sample, 150 samples, tripled for back-pressure, plus drains
  localparam int WATCHDOG_CYCLES = 3 * 150 * 80 + 2500;

  logic        wb_clk, wb_rst, wb_cyc, wb_stb, wb_we, wb_ack;
  logic [15:0] wb_adr, wb_dat_w, wb_dat_r;
  logic        adc_start, cal_req, adc_calibrate, adc_datavalid;
  logic [4:0]  adc_chnum, sample_chan;
  logic [11:0] adc_result, sample_data;
  logic [9:0]  current_stb, cmon_set;
  logic [10:0] temp_stb, tmon_set;
  logic [31:0] bypass_set;
  logic        sample_valid, bp_mode;
  logic        sample_ready = 1'b1;
  logic [31:0] bp_seed = LCG_SEED;
  logic [4:0]  got_chan [$];
  logic [11:0] got_data [$];
  int          sample_base = 0;
  int          n_start = 0;
  int          stb_run = 0;
  int          stb_at_sample = 0;
  int          errors = 0;

  adc_subsystem i_dut (
    .wb_clk_i (wb_clk), .wb_rst_i (wb_rst), .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb),
    .wb_we_i (wb_we), .wb_adr_i (wb_adr), .wb_dat_i (wb_dat_w), .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack), .adc_start_o (adc_start), .adc_chnum_o (adc_chnum),
    .adc_calibrate_i (adc_calibrate), .adc_datavalid_i (adc_datavalid),
    .adc_result_i (adc_result), .current_stb_o (current_stb), .temp_stb_o (temp_stb),
    .sample_valid_o (sample_valid), .sample_data_o (sample_data),
    .sample_chan_o (sample_chan), .sample_ready_i (sample_ready)
  );

  adc_conv_model i_conv (
    .wb_clk_i (wb_clk), .start_i (adc_start), .chnum_i (adc_chnum), .cal_req_i (cal_req),
    .calibrate_o (adc_calibrate), .datavalid_o (adc_datavalid), .result_o (adc_result)
  );

  initial begin
    wb_clk = 1'b0;
    forever #4 wb_clk = ~wb_clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [11:0] expected_result(input int ch);
    return 12'((ch * 97 + 5) % 4096);
  endfunction

  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Monitors for start pulses, strobes and delivered samples
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge wb_clk) begin
    logic [20:0] exp_stb;
    if (!wb_rst && adc_start) begin
      n_start++;
      exp_stb = '0;
      for (int k = 0; k < adc_pkg::CMON_N; k++) begin
        exp_stb[11 + k] = cmon_set[k] && (adc_pkg::CMON_CHAN[k] == adc_chnum);
      end
      for (int k = 0; k < adc_pkg::TMON_N; k++) begin
        exp_stb[k] = tmon_set[k] && (adc_pkg::TMON_CHAN[k] == adc_chnum);
      end
      check(!bypass_set[adc_chnum], $sformatf("start on bypassed channel %0d", adc_chnum));
      check({current_stb, temp_stb} == exp_stb, $sformatf("strobes %h on channel %0d, expected %h",
            {current_stb, temp_stb}, adc_chnum, exp_stb));
      check(exp_stb == '0 || stb_run >= int'(adc_pkg::STB_CYCLES),
            $sformatf("strobe held only %0d cycles before channel %0d", stb_run, adc_chnum));
    end
    if (!wb_rst && sample_valid && sample_ready) begin
      got_chan.push_back(sample_chan);
      got_data.push_back(sample_data);
      if ({current_stb, temp_stb} != '0) stb_at_sample++;
    end
    stb_run = ({current_stb, temp_stb} != '0) ? stb_run + 1 : 0;
  end

  always @(negedge wb_clk) begin
    bp_seed = lcg_step(bp_seed);
    // Ready about one cycle in eight in the back-pressure test so the stage fills up
    sample_ready = bp_mode ? (bp_seed[22:20] == 3'b000) : 1'b1;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge wb_clk);
    $display("Watchdog expired, the tests did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus and sequencing helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic apply_reset();
    @(negedge wb_clk);
    wb_rst = 1'b1;
    cal_req = 1'b0;
    bypass_set = '0;
    cmon_set = '0;
    tmon_set = '0;
    repeat (8) @(negedge wb_clk);
    wb_rst = 1'b0;
    sample_base = got_chan.size();
  endtask

  task automatic wb_xfer(input logic we, input logic [15:0] adr, input logic [15:0] wdat,
                         output logic [15:0] rdat);
    int n;
    n = 0;
    @(negedge wb_clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdat;
    do begin
      @(negedge wb_clk);
      n++;
    end while (!wb_ack && n < 8);
    rdat = wb_dat_r;
    if (!wb_ack) begin
      errors++;
      $display("Wishbone access to address %h was never acknowledged", adr);
    end
    check(n == 1, $sformatf("ack after %0d cycles at address %h", n, adr));
    // Request stays up across the ack edge, so a held ack would show here
    @(negedge wb_clk);
    check(!wb_ack, $sformatf("ack longer than one cycle at address %h", adr));
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic reg_write(input logic [15:0] adr, input logic [15:0] wdat);
    logic [15:0] unused;
    wb_xfer(1'b1, adr, wdat, unused);
  endtask

  task automatic collect(input int n);
    int waited;
    waited = 0;
    while (got_chan.size() < sample_base + n && waited < 12000) begin
      @(negedge wb_clk);
      waited++;
    end
    if (got_chan.size() < sample_base + n) begin
      errors++;
      $display("Timed out after %0d cycles waiting for %0d samples", waited, n);
    end
  endtask

  // Disable, then let the channel in flight finish and deliver
  task automatic stop_scan();
    reg_write(adc_pkg::REG_ADC_EN, 16'h0000);
    repeat (150) @(negedge wb_clk);
  endtask

  // Scan starts at channel 0 after reset and skips masked channels
  task automatic check_samples(input logic [31:0] mask);
    int ch;
    ch = 0;
    for (int i = sample_base; i < got_chan.size(); i++) begin
      while (mask[ch]) ch = (ch + 1) % 32;
      check(got_chan[i] == 5'(ch) && got_data[i] == expected_result(ch),
            $sformatf("sample %0d is ch %0d data %h, expected ch %0d data %h",
                      i - sample_base, got_chan[i], got_data[i], ch, expected_result(ch)));
      ch = (ch + 1) % 32;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_regs();
    logic [15:0] adr_list [7];
    logic [15:0] wval [7];
    logic [15:0] width_mask [7];
    logic [15:0] rd;
    adr_list = '{adc_pkg::REG_BYPASS_LO, adc_pkg::REG_BYPASS_HI, adc_pkg::REG_CMON_EN,
                 adc_pkg::REG_TMON_EN, adc_pkg::REG_ADC_EN, 16'h0005, 16'h8003};
    wval = '{16'ha5c3, 16'h3cf1, 16'hfd2e, 16'hb7d4, 16'h7fff, 16'hffff, 16'h1234};
    width_mask = '{16'hffff, 16'hffff, 16'h03ff, 16'h07ff, 16'h0001, 16'h0000, 16'h0000};
    apply_reset();
    cal_req = 1'b1;  // Keeps the sequencer idle while the enable bit is set
    for (int i = 0; i < 7; i++) reg_write(adr_list[i], wval[i]);
    for (int i = 0; i < 7; i++) begin
      wb_xfer(1'b0, adr_list[i], 16'h0000, rd);
      check(rd == (wval[i] & width_mask[i]), $sformatf("read %h from address %h, expected %h",
            rd, adr_list[i], wval[i] & width_mask[i]));
    end
  endtask

  task automatic test_plain_scan();
    apply_reset();
    reg_write(adc_pkg::REG_ADC_EN, 16'h0001);
    collect(40);  // More than one loop to see the wrap
    stop_scan();
    check_samples(32'h0);
  endtask

  task automatic test_bypass();
    apply_reset();
    bypass_set = 32'h8421_0c06;
    reg_write(adc_pkg::REG_BYPASS_LO, bypass_set[15:0]);
    reg_write(adc_pkg::REG_BYPASS_HI, bypass_set[31:16]);
    reg_write(adc_pkg::REG_ADC_EN, 16'h0001);
    collect(30);
    stop_scan();
    check_samples(bypass_set);
  endtask

  task automatic test_monitor_strobes();
    int late_before;
    apply_reset();
    late_before = stb_at_sample;
    cmon_set = 10'h125;
    tmon_set = 11'h44a;  // Includes monitor 10 on channel 31
    reg_write(adc_pkg::REG_CMON_EN, 16'(cmon_set));
    reg_write(adc_pkg::REG_TMON_EN, 16'(tmon_set));
    reg_write(adc_pkg::REG_ADC_EN, 16'h0001);
    collect(32);
    stop_scan();
    check_samples(32'h0);
    check(stb_at_sample == late_before, "strobe still high when a sample was delivered");
  endtask

  task automatic test_back_pressure();
    apply_reset();
    bp_mode = 1'b1;
    reg_write(adc_pkg::REG_ADC_EN, 16'h0001);
    collect(40);
    bp_mode = 1'b0;
    stop_scan();
    check_samples(32'h0);
  endtask

  task automatic test_hold_off();
    int starts;
    apply_reset();
    starts = n_start;
    repeat (200) @(negedge wb_clk);
    check(n_start == starts && got_chan.size() == sample_base, "activity while disabled");
    cal_req = 1'b1;
    reg_write(adc_pkg::REG_ADC_EN, 16'h0001);
    repeat (200) @(negedge wb_clk);
    check(n_start == starts && got_chan.size() == sample_base, "activity during calibration");
    cal_req = 1'b0;
    collect(6);
    stop_scan();
    check_samples(32'h0);
  endtask

  initial begin
    wb_rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    cal_req = 1'b0;
    bp_mode = 1'b0;
    test_regs();
    test_plain_scan();
    test_bypass();
    test_monitor_strobes();
    test_back_pressure();
    test_hold_off();
    $display("Simulation finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- rtl/adc_pkg.sv
package adc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Converter geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int ADC_CHANNELS = 32;
  localparam int ADC_RES_W    = 12;
  localparam int CHAN_W       = 5;
  localparam int CMON_N       = 10;
  localparam int TMON_N       = 11;

  localparam int STB_W = 9;
  localparam logic [STB_W-1:0] STB_CYCLES = 9'd40;  // Monitor settling time in clocks

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Wishbone register map (word addresses)
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int WB_AW = 16;
  localparam int WB_DW = 16;

  localparam logic [WB_AW-1:0] REG_BYPASS_LO = 16'd0;
  localparam logic [WB_AW-1:0] REG_BYPASS_HI = 16'd1;
  localparam logic [WB_AW-1:0] REG_CMON_EN   = 16'd2;
  localparam logic [WB_AW-1:0] REG_TMON_EN   = 16'd3;
  localparam logic [WB_AW-1:0] REG_ADC_EN    = 16'd4;

  // Channel carrying each monitor, index k is monitor k
  localparam logic [CHAN_W-1:0] CMON_CHAN [CMON_N] = '{
    5'd2, 5'd5, 5'd8, 5'd11, 5'd14, 5'd17, 5'd20, 5'd23, 5'd26, 5'd29
  };
  localparam logic [CHAN_W-1:0] TMON_CHAN [TMON_N] = '{
    5'd3, 5'd6, 5'd9, 5'd12, 5'd15, 5'd18, 5'd21, 5'd24, 5'd27, 5'd30, 5'd31
  };

  typedef enum logic [2:0] {
    SCAN_IDLE,
    SCAN_SETTLE,
    SCAN_START,
    SCAN_WAIT,
    SCAN_NEXT
  } scan_state_e;

endpackage

//--- rtl/adc_result_out.sv
module adc_result_out (
  input  logic                          wb_clk_i,
  input  logic                          wb_rst_i,
  input  logic                          res_valid_i,
  input  logic [adc_pkg::ADC_RES_W-1:0] res_data_i,
  input  logic [adc_pkg::CHAN_W-1:0]    res_chan_i,
  output logic                          res_ready_o,
  output logic                          sample_valid_o,
  output logic [adc_pkg::ADC_RES_W-1:0] sample_data_o,
  output logic [adc_pkg::CHAN_W-1:0]    sample_chan_o,
  input  logic                          sample_ready_i
);

  // Slot is free when empty or being drained this cycle
  assign res_ready_o = ~sample_valid_o | sample_ready_i;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      sample_valid_o <= 1'b0;
    end else if (res_ready_o) begin
      sample_valid_o <= res_valid_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (res_valid_i && res_ready_o) begin
      sample_data_o <= res_data_i;
      sample_chan_o <= res_chan_i;
    end
  end

  a_hold_stable: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    (sample_valid_o && !sample_ready_i) |=>
      (sample_valid_o && $stable(sample_data_o) && $stable(sample_chan_o))
  ) else $error("Sample changed while stalled");

endmodule

//--- rtl/adc_scan_seq.sv
module adc_scan_seq (
  input  logic                             wb_clk_i,
  input  logic                             wb_rst_i,
  input  logic [adc_pkg::ADC_CHANNELS-1:0] bypass_mask_i,
  input  logic [adc_pkg::CMON_N-1:0]       cmon_en_i,
  input  logic [adc_pkg::TMON_N-1:0]       tmon_en_i,
  input  logic                             adc_en_i,
  input  logic                             adc_calibrate_i,
  input  logic                             adc_datavalid_i,
  input  logic [adc_pkg::ADC_RES_W-1:0]    adc_result_i,
  output logic                             adc_start_o,
  output logic [adc_pkg::CHAN_W-1:0]       adc_chnum_o,
  output logic [adc_pkg::CMON_N-1:0]       current_stb_o,
  output logic [adc_pkg::TMON_N-1:0]       temp_stb_o,
  output logic                             res_valid_o,
  output logic [adc_pkg::ADC_RES_W-1:0]    res_data_o,
  output logic [adc_pkg::CHAN_W-1:0]       res_chan_o,
  input  logic                             res_ready_i
);

  adc_pkg::scan_state_e             state_q;
  logic [adc_pkg::CHAN_W-1:0]       chan_q;
  logic [adc_pkg::STB_W-1:0]        stb_cnt_q;
  logic                             dv_prev_q;

  logic [adc_pkg::CMON_N-1:0]       cmon_sel;
  logic [adc_pkg::TMON_N-1:0]       tmon_sel;
  logic                             mon_hit;
  logic                             dv_rise;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Channel to monitor decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    for (int k = 0; k < adc_pkg::CMON_N; k++) begin
      cmon_sel[k] = (chan_q == adc_pkg::CMON_CHAN[k]);
    end
    for (int k = 0; k < adc_pkg::TMON_N; k++) begin
      tmon_sel[k] = (chan_q == adc_pkg::TMON_CHAN[k]);
    end
  end

  assign mon_hit = (|(cmon_sel & cmon_en_i)) | (|(tmon_sel & tmon_en_i));
  assign dv_rise = adc_datavalid_i & ~dv_prev_q;  // Only the edge counts, the level may linger

  assign adc_chnum_o = chan_q;
  assign res_chan_o  = chan_q;  // Channel only advances after the hand-off

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Scan FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q       <= adc_pkg::SCAN_IDLE;
      chan_q        <= '0;
      stb_cnt_q     <= '0;
      dv_prev_q     <= 1'b0;
      adc_start_o   <= 1'b0;
      current_stb_o <= '0;
      temp_stb_o    <= '0;
      res_valid_o   <= 1'b0;
    end else begin
      adc_start_o <= 1'b0;
      dv_prev_q   <= adc_datavalid_i;
      case (state_q)
        adc_pkg::SCAN_IDLE: begin
          if (adc_en_i && !adc_calibrate_i) begin
            if (bypass_mask_i[chan_q]) begin
              state_q <= adc_pkg::SCAN_NEXT;
            end else if (mon_hit) begin
              state_q       <= adc_pkg::SCAN_SETTLE;
              stb_cnt_q     <= adc_pkg::STB_CYCLES;
              current_stb_o <= cmon_sel & cmon_en_i;
              temp_stb_o    <= tmon_sel & tmon_en_i;
            end else begin
              state_q <= adc_pkg::SCAN_START;
            end
          end
        end
        adc_pkg::SCAN_SETTLE: begin
          if (stb_cnt_q != '0) begin
            stb_cnt_q <= stb_cnt_q - 1'b1;
          end else begin
            state_q <= adc_pkg::SCAN_START;
          end
        end
        adc_pkg::SCAN_START: begin
          adc_start_o <= 1'b1;
          state_q     <= adc_pkg::SCAN_WAIT;
        end
        adc_pkg::SCAN_WAIT: begin
          if (dv_rise) begin
            current_stb_o <= '0;
            temp_stb_o    <= '0;
            res_valid_o   <= 1'b1;
            state_q       <= adc_pkg::SCAN_NEXT;
          end
        end
        adc_pkg::SCAN_NEXT: begin
          // Stall here until the result stage takes the sample
          if (!res_valid_o || res_ready_i) begin
            res_valid_o <= 1'b0;
            chan_q      <= chan_q + 1'b1;  // Wraps 31 to 0
            state_q     <= adc_pkg::SCAN_IDLE;
          end
        end
        default: state_q <= adc_pkg::SCAN_IDLE;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (state_q == adc_pkg::SCAN_WAIT && dv_rise) begin
      res_data_o <= adc_result_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_start_pulse: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    adc_start_o |=> !adc_start_o
  ) else $error("adc_start_o high for two cycles");

  // The converter latches the channel with start and must see it unchanged
  a_chnum_stable: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    (state_q == adc_pkg::SCAN_WAIT) |=> $stable(adc_chnum_o)
  ) else $error("adc_chnum_o changed during conversion");

  a_stb_onehot: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    $onehot0({current_stb_o, temp_stb_o})
  ) else $error("More than one monitor strobe active");

endmodule

//--- rtl/adc_subsystem.sv
module adc_subsystem (
  input  logic                          wb_clk_i,
  input  logic                          wb_rst_i,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [adc_pkg::WB_AW-1:0]     wb_adr_i,
  input  logic [adc_pkg::WB_DW-1:0]     wb_dat_i,
  output logic [adc_pkg::WB_DW-1:0]     wb_dat_o,
  output logic                          wb_ack_o,
  output logic                          adc_start_o,
  output logic [adc_pkg::CHAN_W-1:0]    adc_chnum_o,
  input  logic                          adc_calibrate_i,
  input  logic                          adc_datavalid_i,
  input  logic [adc_pkg::ADC_RES_W-1:0] adc_result_i,
  output logic [adc_pkg::CMON_N-1:0]    current_stb_o,
  output logic [adc_pkg::TMON_N-1:0]    temp_stb_o,
  output logic                          sample_valid_o,
  output logic [adc_pkg::ADC_RES_W-1:0] sample_data_o,
  output logic [adc_pkg::CHAN_W-1:0]    sample_chan_o,
  input  logic                          sample_ready_i
);

  logic [adc_pkg::ADC_CHANNELS-1:0] bypass_mask;
  logic [adc_pkg::CMON_N-1:0]       cmon_en;
  logic [adc_pkg::TMON_N-1:0]       tmon_en;
  logic                             adc_en;

  logic                             res_valid;
  logic                             res_ready;
  logic [adc_pkg::ADC_RES_W-1:0]    res_data;
  logic [adc_pkg::CHAN_W-1:0]       res_chan;

  adc_wb_regs i_regs (
    .wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i,
    .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .bypass_mask_o (bypass_mask),
    .cmon_en_o     (cmon_en),
    .tmon_en_o     (tmon_en),
    .adc_en_o      (adc_en)
  );

  adc_scan_seq i_seq (
    .wb_clk_i, .wb_rst_i,
    .bypass_mask_i (bypass_mask),
    .cmon_en_i     (cmon_en),
    .tmon_en_i     (tmon_en),
    .adc_en_i      (adc_en),
    .adc_calibrate_i, .adc_datavalid_i, .adc_result_i,
    .adc_start_o, .adc_chnum_o, .current_stb_o, .temp_stb_o,
    .res_valid_o   (res_valid),
    .res_data_o    (res_data),
    .res_chan_o    (res_chan),
    .res_ready_i   (res_ready)
  );

  adc_result_out i_out (
    .wb_clk_i, .wb_rst_i,
    .res_valid_i (res_valid),
    .res_data_i  (res_data),
    .res_chan_i  (res_chan),
    .res_ready_o (res_ready),
    .sample_valid_o, .sample_data_o, .sample_chan_o, .sample_ready_i
  );

endmodule

//--- rtl/adc_wb_regs.sv
module adc_wb_regs (
  input  logic                             wb_clk_i,
  input  logic                             wb_rst_i,
  input  logic                             wb_cyc_i,
  input  logic                             wb_stb_i,
  input  logic                             wb_we_i,
  input  logic [adc_pkg::WB_AW-1:0]        wb_adr_i,
  input  logic [adc_pkg::WB_DW-1:0]        wb_dat_i,
  output logic [adc_pkg::WB_DW-1:0]        wb_dat_o,
  output logic                             wb_ack_o,
  output logic [adc_pkg::ADC_CHANNELS-1:0] bypass_mask_o,
  output logic [adc_pkg::CMON_N-1:0]       cmon_en_o,
  output logic [adc_pkg::TMON_N-1:0]       tmon_en_o,
  output logic                             adc_en_o
);

  logic                      wb_req;
  logic [adc_pkg::WB_DW-1:0] rd_word;

  // A new request is only taken once the previous ack has dropped
  assign wb_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read mux
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    rd_word = '0;  // Unknown addresses read zero
    case (wb_adr_i)
      adc_pkg::REG_BYPASS_LO: rd_word = bypass_mask_o[15:0];
      adc_pkg::REG_BYPASS_HI: rd_word = bypass_mask_o[31:16];
      adc_pkg::REG_CMON_EN:   rd_word[adc_pkg::CMON_N-1:0] = cmon_en_o;
      adc_pkg::REG_TMON_EN:   rd_word[adc_pkg::TMON_N-1:0] = tmon_en_o;
      adc_pkg::REG_ADC_EN:    rd_word[0] = adc_en_o;
      default:                rd_word = '0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control registers and ack
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o      <= 1'b0;
      bypass_mask_o <= '0;
      cmon_en_o     <= '0;
      tmon_en_o     <= '0;
      adc_en_o      <= 1'b0;
    end else begin
      wb_ack_o <= wb_req;
      if (wb_req && wb_we_i) begin
        case (wb_adr_i)
          adc_pkg::REG_BYPASS_LO: bypass_mask_o[15:0]  <= wb_dat_i;
          adc_pkg::REG_BYPASS_HI: bypass_mask_o[31:16] <= wb_dat_i;
          adc_pkg::REG_CMON_EN:   cmon_en_o <= wb_dat_i[adc_pkg::CMON_N-1:0];
          adc_pkg::REG_TMON_EN:   tmon_en_o <= wb_dat_i[adc_pkg::TMON_N-1:0];
          adc_pkg::REG_ADC_EN:    adc_en_o  <= wb_dat_i[0];
          default: ;  // Write to a hole is dropped
        endcase
      end
    end
  end

  // Read data is captured with the request and presented in the ack cycle
  always_ff @(posedge wb_clk_i) begin
    if (wb_req && !wb_we_i) begin
      wb_dat_o <= rd_word;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Each request gets a single-cycle ack even when cyc/stb stay asserted
  a_ack_single: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o
  ) else $error("wb_ack_o held high for two cycles");

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module adc_tb -f build.f -o adc_sim
./obj_dir/adc_sim | tee sim.log
if grep -q "TEST RESULT: PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
